// ==== sources.f ====
common.sv
video_ram.sv
axil_vram_bridge.sv
vga_timing.sv
fb_scanout.sv
display_top.sv
display_props.sv
tb_display_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing --assert -Wall
TOP       = tb_display_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_display_top.sv ====
`timescale 1ns/10ps

module tb_display_top;
    import common::*;

    localparam int CPU_PERIOD   = 100;
    localparam int PXL_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int FB_WORDS     = VRAM_BYTES / 4;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL * PXL_PERIOD / CPU_PERIOD;

    typedef struct {
        string name;
        bit    is_write;
        word_t addr;
        word_t data;
        strb_t strb;
        word_t exp_data;
        resp_t exp_resp;
        int    hold;
    } bus_op_t;

    logic      cpu_clk_i;
    logic      pxl_clk_i;
    logic      rst_i;
    axil_req_t req;
    axil_rsp_t rsp;
    byte_t     rgb;
    logic      hsync;
    logic      vsync;
    logic      de;

    bus_op_t ops[$];
    byte_t   shadow_mem [VRAM_BYTES];
    ctrl_t   shadow_ctrl;
    int      errors;
    int      prop_fails;
    int      timeout_cycles = 0;
    int      cycle_cnt = 0;

    display_top UUT (
        .cpu_clk_i  (cpu_clk_i),
        .rst_i      (rst_i),
        .pxl_clk_i  (pxl_clk_i),
        .axil_req_i (req),
        .axil_rsp_o (rsp),
        .rgb_o      (rgb),
        .hsync_o    (hsync),
        .vsync_o    (vsync),
        .de_o       (de)
    );

    initial begin
        cpu_clk_i = 1'b0;
        forever #(CPU_PERIOD / 2) cpu_clk_i = ~cpu_clk_i;
    end

    initial begin
        pxl_clk_i = 1'b0;
        forever #(PXL_PERIOD / 2) pxl_clk_i = ~pxl_clk_i;
    end

    always @(posedge cpu_clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d CPU cycles", timeout_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    function automatic void add_op(input string name, input bit is_write, input word_t addr,
                                   input word_t data, input strb_t strb, input word_t exp_data,
                                   input resp_t exp_resp, input int hold);
        bus_op_t op;
        op.name     = name;
        op.is_write = is_write;
        op.addr     = addr;
        op.data     = data;
        op.strb     = strb;
        op.exp_data = exp_data;
        op.exp_resp = exp_resp;
        op.hold     = hold;
        ops.push_back(op);
    endfunction

    function automatic void build_table();
        add_op("wr_word0",      1, 32'h0000, 32'h1234_5678, 4'hF, 32'h0, OKAY, 0);
        add_op("rd_word0",      0, 32'h0000, 32'h0, 4'h0, 32'h1234_5678, OKAY, 0);
        add_op("wr_word_mid",   1, 32'h07F8, 32'hCAFE_F00D, 4'hF, 32'h0, OKAY, 0);
        add_op("rd_word_mid",   0, 32'h07F8, 32'h0, 4'h0, 32'hCAFE_F00D, OKAY, 0);
        add_op("wr_word_top",   1, 32'h0FFC, 32'hA5A5_5A5A, 4'hF, 32'h0, OKAY, 0);
        add_op("rd_word_top",   0, 32'h0FFC, 32'h0, 4'h0, 32'hA5A5_5A5A, OKAY, 0);
        add_op("wr_base",       1, 32'h0004, 32'h1122_3344, 4'hF, 32'h0, OKAY, 0);
        add_op("wr_strb_5",     1, 32'h0004, 32'hAABB_CCDD, 4'h5, 32'h0, OKAY, 0);
        add_op("wr_strb_8",     1, 32'h0006, 32'h9900_0000, 4'h8, 32'h0, OKAY, 0);
        add_op("rd_strb",       0, 32'h0004, 32'h0, 4'h0, 32'h99BB_33DD, OKAY, 0);
        add_op("wr_ctrl_full",  1, 32'h1000, 32'hFFFF_FE5A, 4'hF, 32'h0, OKAY, 0);
        add_op("wr_ctrl_lane1", 1, 32'h1000, 32'hFFFF_FFFF, 4'h2, 32'h0, OKAY, 0);
        add_op("rd_ctrl_stall", 0, 32'h1000, 32'h0, 4'h0, 32'h0000_015A, OKAY, 4);
        add_op("wr_err_1004",   1, 32'h1004, 32'hDEAD_BEEF, 4'hF, 32'h0, SLVERR, 3);
        add_op("rd_err_1004",   0, 32'h1004, 32'h0, 4'h0, 32'h0, SLVERR, 0);
        add_op("wr_err_2000",   1, 32'h2000, 32'hDEAD_BEEF, 4'hF, 32'h0, SLVERR, 0);
        add_op("rd_err_2000",   0, 32'h2000, 32'h0, 4'h0, 32'h0, SLVERR, 0);
        add_op("rd_word0_stall", 0, 32'h0000, 32'h0, 4'h0, 32'h1234_5678, OKAY, 5);
    endfunction

    // shadow follows the address map rules
    function automatic void update_shadow(input word_t addr, input word_t data, input strb_t strb);
        int base;
        base = int'(addr) & ~3;
        if (addr < word_t'(VRAM_BYTES)) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    shadow_mem[base + i] = data[8*i +: 8];
                end
            end
        end else if (addr == CTRL_ADDR) begin
            if (strb[0]) begin
                shadow_ctrl.border = data[7:0];
            end
            if (strb[1]) begin
                shadow_ctrl.enable = data[8];
            end
        end
    endfunction

    function automatic word_t shadow_word(input word_t addr);
        int base;
        base = int'(addr) & ~3;
        return {shadow_mem[base + 3], shadow_mem[base + 2], shadow_mem[base + 1], shadow_mem[base]};
    endfunction

    function automatic byte_t expected_pixel(input int x, input int y);
        if (!shadow_ctrl.enable) begin
            return '0;
        end
        if (x < (FB_WIDTH << PIXEL_SHIFT)) begin
            return shadow_mem[(y >> PIXEL_SHIFT) * FB_WIDTH + (x >> PIXEL_SHIFT)];
        end
        return shadow_ctrl.border;
    endfunction

    task automatic bus_write(input string name, input word_t addr, input word_t data,
                             input strb_t strb, input int hold, output resp_t resp);
        @(posedge cpu_clk_i);
        #1;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.wstrb   = strb;
        do @(negedge cpu_clk_i); while (!rsp.awready);
        if (!rsp.wready) begin
            report_failure({name, ": wready did not rise with awready"});
        end
        @(posedge cpu_clk_i);
        #1;
        // under back-pressure the same write is offered again and has to wait
        req.awvalid = (hold > 0);
        req.wvalid  = (hold > 0);
        do @(negedge cpu_clk_i); while (!rsp.bvalid);
        resp = rsp.bresp;
        // bready held low
        repeat (hold) begin
            @(negedge cpu_clk_i);
            if (!rsp.bvalid || rsp.bresp != resp) begin
                report_failure({name, ": write response changed while bready was low"});
            end
            if (rsp.awready || rsp.wready) begin
                report_failure({name, ": write accepted while a write response was pending"});
            end
        end
        @(posedge cpu_clk_i);
        #1;
        req.bready = 1'b1;
        @(posedge cpu_clk_i);
        #1;
        req.bready = 1'b0;
        if (hold > 0) begin
            do @(negedge cpu_clk_i); while (!rsp.awready);
            @(posedge cpu_clk_i);
            #1;
            req.awvalid = 1'b0;
            req.wvalid  = 1'b0;
            do @(negedge cpu_clk_i); while (!rsp.bvalid);
            if (rsp.bresp != resp) begin
                report_failure({name, ": repeated write gave a different response"});
            end
            @(posedge cpu_clk_i);
            #1;
            req.bready = 1'b1;
            @(posedge cpu_clk_i);
            #1;
            req.bready = 1'b0;
        end
    endtask

    task automatic bus_read(input string name, input word_t addr, input int hold,
                            output word_t data, output resp_t resp);
        @(posedge cpu_clk_i);
        #1;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        do @(negedge cpu_clk_i); while (!rsp.arready);
        @(posedge cpu_clk_i);
        #1;
        // under back-pressure the same read is offered again and has to wait
        req.arvalid = (hold > 0);
        do @(negedge cpu_clk_i); while (!rsp.rvalid);
        data = rsp.rdata;
        resp = rsp.rresp;
        repeat (hold) begin
            @(negedge cpu_clk_i);
            if (!rsp.rvalid || rsp.rdata != data || rsp.rresp != resp) begin
                report_failure({name, ": read response changed while rready was low"});
            end
            if (rsp.arready) begin
                report_failure({name, ": address accepted while a read response was pending"});
            end
        end
        @(posedge cpu_clk_i);
        #1;
        req.rready = 1'b1;
        @(posedge cpu_clk_i);
        #1;
        req.rready = 1'b0;
        if (hold > 0) begin
            do @(negedge cpu_clk_i); while (!rsp.arready);
            @(posedge cpu_clk_i);
            #1;
            req.arvalid = 1'b0;
            do @(negedge cpu_clk_i); while (!rsp.rvalid);
            if (rsp.rdata != data || rsp.rresp != resp) begin
                report_failure({name, ": repeated read gave a different response"});
            end
            @(posedge cpu_clk_i);
            #1;
            req.rready = 1'b1;
            @(posedge cpu_clk_i);
            #1;
            req.rready = 1'b0;
        end
    endtask

    task automatic apply_op(input bus_op_t op);
        resp_t resp;
        word_t rdata;
        if (op.is_write) begin
            bus_write(op.name, op.addr, op.data, op.strb, op.hold, resp);
            update_shadow(op.addr, op.data, op.strb);
        end else begin
            bus_read(op.name, op.addr, op.hold, rdata, resp);
            if (rdata != op.exp_data) begin
                report_mismatch({op.name, " rdata"}, op.exp_data, rdata);
            end
            if (op.addr < word_t'(VRAM_BYTES) && rdata != shadow_word(op.addr)) begin
                report_mismatch({op.name, " shadow"}, shadow_word(op.addr), rdata);
            end
        end
        if (resp != op.exp_resp) begin
            report_mismatch({op.name, " resp"}, word_t'(op.exp_resp), word_t'(resp));
        end
    endtask

    task automatic fill_frame_buffer();
        resp_t resp;
        word_t data;
        for (int w = 0; w < FB_WORDS; w++) begin
            data = $urandom;
            bus_write("fill", word_t'(w * 4), data, 4'hF, 0, resp);
            update_shadow(word_t'(w * 4), data, 4'hF);
            if (resp != OKAY) begin
                report_mismatch("fill resp", word_t'(OKAY), word_t'(resp));
            end
        end
    endtask

    task automatic set_ctrl(input string name, input logic enable, input byte_t border);
        resp_t resp;
        word_t data;
        data = {23'b0, enable, border};
        bus_write(name, CTRL_ADDR, data, 4'h3, 0, resp);
        update_shadow(CTRL_ADDR, data, 4'h3);
        if (resp != OKAY) begin
            report_mismatch({name, " resp"}, word_t'(OKAY), word_t'(resp));
        end
    endtask

    task automatic wait_vsync_low();
        do @(negedge pxl_clk_i); while (vsync);
    endtask

    // one frame between the end of vsync and the next vsync
    task automatic check_frame(input string name);
        int    x;
        int    y;
        bit    de_prev;
        byte_t exp;
        do @(negedge pxl_clk_i); while (!vsync);
        x = 0;
        y = 0;
        de_prev = 1'b0;
        while (vsync) begin
            @(negedge pxl_clk_i);
            if (!hsync) begin
                x = 0;
            end
            if (de) begin
                exp = expected_pixel(x, y);
                if (rgb != exp) begin
                    report_mismatch($sformatf("%s x=%0d y=%0d", name, x, y), word_t'(exp),
                                    word_t'(rgb));
                end
                x++;
            end else if (de_prev) begin
                if (x != H_ACTIVE) begin
                    report_failure($sformatf("%s: line %0d had %0d de cycles", name, y, x));
                end
                y++;
            end
            de_prev = de;
        end
        if (y != V_ACTIVE) begin
            report_failure($sformatf("%s: frame had %0d active lines", name, y));
        end
    endtask

    initial begin
        void'($urandom(23175));
        errors      = 0;
        rst_i       = 1'b1;
        req         = '0;
        shadow_ctrl = '0;
        foreach (shadow_mem[i]) begin
            shadow_mem[i] = '0;
        end
        build_table();
        timeout_cycles = RESET_CYCLES + ops.size() * 10 + FB_WORDS * 10 + 3 * FRAME_CYCLES;
        repeat (RESET_CYCLES) @(posedge cpu_clk_i);
        #1;
        rst_i = 1'b0;

        foreach (ops[i]) begin
            apply_op(ops[i]);
        end

        fill_frame_buffer();
        // control only changes during vsync
        wait_vsync_low();
        set_ctrl("ctrl_enable", 1'b1, 8'hE3);
        check_frame("frame_on");
        set_ctrl("ctrl_disable", 1'b0, 8'hE3);
        check_frame("frame_off");

        prop_fails = UUT.u_bridge.u_props.bvalid_fails + UUT.u_bridge.u_props.rvalid_fails
                   + UUT.u_bridge.u_props.wr_latency_fails
                   + UUT.u_bridge.u_props.rd_latency_fails;
        if (prop_fails != 0) begin
            report_failure($sformatf("%0d bus handshake assertions failed", prop_fails));
        end
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== display_props.sv ====
`timescale 1ns/10ps

module display_props (
    input logic              cpu_clk_i,
    input logic              rst_i,
    input common::axil_req_t axil_req_i,
    input common::axil_rsp_t axil_rsp_i
);
    import common::*;

    int bvalid_fails     = 0;
    int rvalid_fails     = 0;
    int wr_latency_fails = 0;
    int rd_latency_fails = 0;

    bvalid_hold: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
        else begin
            $error("bvalid dropped before bready");
            bvalid_fails++;
        end

    // data and response frozen while the master stalls
    rvalid_hold: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        axil_rsp_i.rvalid && !axil_req_i.rready |=>
            axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata) && $stable(axil_rsp_i.rresp))
        else begin
            $error("read response changed before rready");
            rvalid_fails++;
        end

    write_latency: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        axil_rsp_i.awready |=> axil_rsp_i.bvalid)
        else begin
            $error("bvalid did not follow write acceptance by one cycle");
            wr_latency_fails++;
        end

    // rvalid rises exactly two cycles after arready
    read_latency: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        axil_rsp_i.rvalid && !$past(axil_rsp_i.rvalid) |-> $past(axil_rsp_i.arready, 2))
        else begin
            $error("rvalid did not rise two cycles after arready");
            rd_latency_fails++;
        end

endmodule

bind axil_vram_bridge display_props u_props (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_i (axil_rsp_o)
);

// ==== display_top.sv ====
`timescale 1ns/10ps

module display_top (
    input  logic              cpu_clk_i,
    input  logic              rst_i,
    input  logic              pxl_clk_i,
    input  common::axil_req_t axil_req_i,
    output common::axil_rsp_t axil_rsp_o,
    output common::byte_t     rgb_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              de_o
);
    import common::*;

    vram_cpu_t vram_cpu;
    word_t     vram_rdata;
    ctrl_t     ctrl;
    scan_t     scan;
    logic      pxl_cs;
    pxl_addr_t pxl_addr;
    byte_t     pxl_data;
    logic      pxl_rst;

    axil_vram_bridge u_bridge (
        .cpu_clk_i    (cpu_clk_i),
        .rst_i        (rst_i),
        .axil_req_i   (axil_req_i),
        .axil_rsp_o   (axil_rsp_o),
        .vram_o       (vram_cpu),
        .vram_rdata_i (vram_rdata),
        .ctrl_o       (ctrl)
    );

    video_ram u_vram (
        .cpu_clk_i         (cpu_clk_i),
        .cpu_port_i        (vram_cpu),
        .cpu_read_data_o   (vram_rdata),
        .pxl_clk_i         (pxl_clk_i),
        .pxl_chip_select_i (pxl_cs),
        .pxl_addr_i        (pxl_addr),
        .pxl_data_o        (pxl_data)
    );

    // pixel clock domain
    vga_timing u_timing (
        .pxl_clk_i (pxl_clk_i),
        .pxl_rst_i (pxl_rst),
        .scan_o    (scan)
    );

    fb_scanout u_scanout (
        .pxl_clk_i         (pxl_clk_i),
        .rst_i             (rst_i),
        .scan_i            (scan),
        .ctrl_i            (ctrl),
        .pxl_chip_select_o (pxl_cs),
        .pxl_addr_o        (pxl_addr),
        .pxl_data_i        (pxl_data),
        .pxl_rst_o         (pxl_rst),
        .rgb_o             (rgb_o),
        .hsync_o           (hsync_o),
        .vsync_o           (vsync_o),
        .de_o              (de_o)
    );

endmodule

// ==== fb_scanout.sv ====
`timescale 1ns/10ps

module fb_scanout (
    input  logic              pxl_clk_i,
    input  logic              rst_i,
    input  common::scan_t     scan_i,
    input  common::ctrl_t     ctrl_i,
    output logic              pxl_chip_select_o,
    output common::pxl_addr_t pxl_addr_o,
    input  common::byte_t     pxl_data_i,
    output logic              pxl_rst_o,
    output common::byte_t     rgb_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              de_o
);
    import common::*;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
        logic in_fb;
    } flags_t;

    logic   rst_meta_r;
    logic   rst_sync_r;
    ctrl_t  ctrl_meta_r;
    ctrl_t  ctrl_sync_r;
    coord_t fb_row;
    coord_t fb_col;
    flags_t flags;
    flags_t flags_d1_r;
    byte_t  rgb_r;
    logic   hsync_r;
    logic   vsync_r;
    logic   de_r;

    // reset into the pixel domain
    always_ff @(posedge pxl_clk_i) begin
        rst_meta_r <= rst_i;
        rst_sync_r <= rst_meta_r;
    end

    assign pxl_rst_o = rst_sync_r;

    // quasi-static, only changed during vertical blanking
    always_ff @(posedge pxl_clk_i) begin
        if (rst_sync_r) begin
            ctrl_meta_r <= '0;
            ctrl_sync_r <= '0;
        end else begin
            ctrl_meta_r <= ctrl_i;
            ctrl_sync_r <= ctrl_meta_r;
        end
    end

    assign fb_row = scan_i.y >> PIXEL_SHIFT;
    assign fb_col = scan_i.x >> PIXEL_SHIFT;

    always_comb begin
        flags.hsync  = scan_i.hsync;
        flags.vsync  = scan_i.vsync;
        flags.active = scan_i.active;
        // x below 512
        flags.in_fb  = scan_i.active && (fb_col < coord_t'(FB_WIDTH));
    end

    assign pxl_chip_select_o = flags.in_fb;
    assign pxl_addr_o = pxl_addr_t'(fb_row) * pxl_addr_t'(FB_WIDTH) + pxl_addr_t'(fb_col);

    // first stage covers the memory latency
    always_ff @(posedge pxl_clk_i) begin
        if (rst_sync_r) begin
            flags_d1_r <= '{1'b1, 1'b1, 1'b0, 1'b0};
            hsync_r    <= 1'b1;
            vsync_r    <= 1'b1;
            de_r       <= 1'b0;
        end else begin
            flags_d1_r <= flags;
            hsync_r    <= flags_d1_r.hsync;
            vsync_r    <= flags_d1_r.vsync;
            de_r       <= flags_d1_r.active;
        end
    end

    always_ff @(posedge pxl_clk_i) begin
        if (!flags_d1_r.active || !ctrl_sync_r.enable) begin
            rgb_r <= '0;
        end else if (flags_d1_r.in_fb) begin
            rgb_r <= pxl_data_i;
        end else begin
            rgb_r <= ctrl_sync_r.border;
        end
    end

    assign rgb_o   = rgb_r;
    assign hsync_o = hsync_r;
    assign vsync_o = vsync_r;
    assign de_o    = de_r;

endmodule

// ==== vga_timing.sv ====
`timescale 1ns/10ps

module vga_timing (
    input  logic          pxl_clk_i,
    input  logic          pxl_rst_i,
    output common::scan_t scan_o
);
    import common::*;

    coord_t h_cnt_r;
    coord_t v_cnt_r;
    logic   h_last;
    logic   v_last;
    logic   in_hsync;
    logic   in_vsync;

    assign h_last = h_cnt_r == coord_t'(H_TOTAL - 1);
    assign v_last = v_cnt_r == coord_t'(V_TOTAL - 1);

    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i) begin
            h_cnt_r <= '0;
            v_cnt_r <= '0;
        end else if (h_last) begin
            h_cnt_r <= '0;
            if (v_last) begin
                v_cnt_r <= '0;
            end else begin
                v_cnt_r <= v_cnt_r + 1'b1;
            end
        end else begin
            h_cnt_r <= h_cnt_r + 1'b1;
        end
    end

    // sync pulses sit after the front porch
    assign in_hsync = (h_cnt_r >= coord_t'(H_ACTIVE + H_FRONT))
                   && (h_cnt_r < coord_t'(H_ACTIVE + H_FRONT + H_SYNC));
    assign in_vsync = (v_cnt_r >= coord_t'(V_ACTIVE + V_FRONT))
                   && (v_cnt_r < coord_t'(V_ACTIVE + V_FRONT + V_SYNC));

    always_comb begin
        scan_o.hsync  = !in_hsync;
        scan_o.vsync  = !in_vsync;
        scan_o.active = (h_cnt_r < coord_t'(H_ACTIVE)) && (v_cnt_r < coord_t'(V_ACTIVE));
        scan_o.x      = h_cnt_r;
        scan_o.y      = v_cnt_r;
    end

endmodule

// ==== axil_vram_bridge.sv ====
`timescale 1ns/10ps

module axil_vram_bridge (
    input  logic              cpu_clk_i,
    input  logic              rst_i,
    input  common::axil_req_t axil_req_i,
    output common::axil_rsp_t axil_rsp_o,
    output common::vram_cpu_t vram_o,
    input  common::word_t     vram_rdata_i,
    output common::ctrl_t     ctrl_o
);
    import common::*;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_WAIT,
        READ_RESP
    } state_t;

    state_t state_r;
    resp_t  bresp_r;
    resp_t  rresp_r;
    word_t  rdata_r;
    logic   rd_mem_r;
    logic   rd_ctrl_r;
    ctrl_t  ctrl_r;

    logic wr_accept;
    logic rd_accept;
    logic wr_mem;
    logic wr_ctrl;
    logic rd_mem;
    logic rd_ctrl;

    // address decode
    assign wr_mem  = axil_req_i.awaddr < word_t'(VRAM_BYTES);
    assign wr_ctrl = axil_req_i.awaddr == CTRL_ADDR;
    assign rd_mem  = axil_req_i.araddr < word_t'(VRAM_BYTES);
    assign rd_ctrl = axil_req_i.araddr == CTRL_ADDR;

    // write wins when both come in together
    assign wr_accept = (state_r == IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
    assign rd_accept = (state_r == IDLE) && axil_req_i.arvalid && !wr_accept;

    always_comb begin
        vram_o.cs = (wr_accept && wr_mem) || (rd_accept && rd_mem);
        if (wr_accept) begin
            vram_o.addr = {axil_req_i.awaddr[11:2], 2'b00};
            vram_o.mask = axil_req_i.wstrb;
        end else begin
            vram_o.addr = {axil_req_i.araddr[11:2], 2'b00};
            vram_o.mask = '0;
        end
        vram_o.wdata = axil_req_i.wdata;
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            state_r <= IDLE;
            ctrl_r  <= '0;
        end else begin
            case (state_r)
                IDLE: begin
                    if (wr_accept) begin
                        state_r <= WRITE_RESP;
                        if (wr_ctrl && axil_req_i.wstrb[0]) begin
                            ctrl_r.border <= axil_req_i.wdata[7:0];
                        end
                        if (wr_ctrl && axil_req_i.wstrb[1]) begin
                            ctrl_r.enable <= axil_req_i.wdata[8];
                        end
                    end else if (rd_accept) begin
                        state_r <= READ_WAIT;
                    end
                end
                // memory word arrives here
                READ_WAIT: state_r <= READ_RESP;
                WRITE_RESP: begin
                    if (axil_req_i.bready) begin
                        state_r <= IDLE;
                    end
                end
                READ_RESP: begin
                    if (axil_req_i.rready) begin
                        state_r <= IDLE;
                    end
                end
                default: state_r <= IDLE;
            endcase
        end
    end

    // response payload
    always_ff @(posedge cpu_clk_i) begin
        if (wr_accept) begin
            bresp_r <= (wr_mem || wr_ctrl) ? OKAY : SLVERR;
        end
        if (rd_accept) begin
            rd_mem_r  <= rd_mem;
            rd_ctrl_r <= rd_ctrl;
        end
        if (state_r == READ_WAIT) begin
            if (rd_mem_r) begin
                rdata_r <= vram_rdata_i;
                rresp_r <= OKAY;
            end else if (rd_ctrl_r) begin
                rdata_r <= {23'b0, ctrl_r};
                rresp_r <= OKAY;
            end else begin
                rdata_r <= '0;
                rresp_r <= SLVERR;
            end
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_accept;
        axil_rsp_o.wready  = wr_accept;
        axil_rsp_o.bvalid  = state_r == WRITE_RESP;
        axil_rsp_o.bresp   = bresp_r;
        axil_rsp_o.arready = rd_accept;
        axil_rsp_o.rvalid  = state_r == READ_RESP;
        axil_rsp_o.rdata   = rdata_r;
        axil_rsp_o.rresp   = rresp_r;
    end

    assign ctrl_o = ctrl_r;

endmodule

// ==== video_ram.sv ====
`timescale 1ns/10ps

module video_ram (
    input  logic              cpu_clk_i,
    input  common::vram_cpu_t cpu_port_i,
    output common::word_t     cpu_read_data_o,

    input  logic              pxl_clk_i,
    input  logic              pxl_chip_select_i,
    input  common::pxl_addr_t pxl_addr_i,
    output common::byte_t     pxl_data_o
);
    import common::*;

    byte_t mem_r [VRAM_BYTES] = '{default: '0};
    word_t cpu_rdata_r;
    byte_t pxl_data_r;

    // cpu side, old data comes back on a write
    always_ff @(posedge cpu_clk_i) begin
        if (cpu_port_i.cs) begin
            for (int i = 0; i < 4; i++) begin
                cpu_rdata_r[8*i +: 8] <= mem_r[cpu_port_i.addr + pxl_addr_t'(i)];
                if (cpu_port_i.mask[i]) begin
                    mem_r[cpu_port_i.addr + pxl_addr_t'(i)] <= cpu_port_i.wdata[8*i +: 8];
                end
            end
        end
    end

    assign cpu_read_data_o = cpu_rdata_r;

    // pixel side, read only
    always_ff @(posedge pxl_clk_i) begin
        if (pxl_chip_select_i) begin
            pxl_data_r <= mem_r[pxl_addr_i];
        end
    end

    assign pxl_data_o = pxl_data_r;

endmodule

// ==== common.sv ====
package common;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  strb_t;
    typedef logic [11:0] pxl_addr_t;
    typedef logic [9:0]  coord_t;

    localparam int    FB_WIDTH    = 64;
    localparam int    FB_HEIGHT   = 64;
    localparam int    VRAM_BYTES  = FB_WIDTH * FB_HEIGHT;
    // one stored pixel covers an 8x8 block on screen
    localparam int    PIXEL_SHIFT = 3;
    localparam word_t CTRL_ADDR   = 32'h0000_1000;

    // 640x480 at 60 Hz
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

    typedef struct packed {
        logic  awvalid;
        word_t awaddr;
        logic  wvalid;
        word_t wdata;
        strb_t wstrb;
        logic  bready;
        logic  arvalid;
        word_t araddr;
        logic  rready;
    } axil_req_t;

    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_t bresp;
        logic  arready;
        logic  rvalid;
        word_t rdata;
        resp_t rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic      cs;
        // byte address, low two bits zero
        pxl_addr_t addr;
        word_t     wdata;
        strb_t     mask;
    } vram_cpu_t;

    typedef struct packed {
        logic  enable;
        byte_t border;
    } ctrl_t;

    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   active;
        coord_t x;
        coord_t y;
    } scan_t;

endpackage
